// ==== refill_bridge.f ====
+incdir+logic
logic/axi_pkg.sv
logic/cache_pkg.sv
logic/refill_fsm.sv
logic/beat_counter.sv
logic/line_assembler.sv
logic/refill_bridge.sv
verif/tb_clock.sv
verif/refill_bridge_tb.sv

// ==== verif/refill_bridge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_bridge_tb;
    import axi_pkg::*;
    import cache_pkg::*;

    localparam int          cycle_limit = 6 * 64;   // 64 cycles for each of six tests
    localparam logic [31:0] data_mask   = 32'hA5A50000;

    logic        aclk;
    logic        rst_n;
    logic        icache_rd_req;
    line_addr_u  icache_rd_addr;
    logic        icache_rd_rdy;
    logic        icache_ret_valid;
    cache_line_t icache_ret_data;
    logic        dcache_rd_req;
    line_addr_u  dcache_rd_addr;
    logic        dcache_rd_rdy;
    logic        dcache_ret_valid;
    cache_line_t dcache_ret_data;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;

    logic        stall_mode;     // random arready and rvalid gaps
    logic        burst_active;   // slave has a burst to return
    logic [31:0] burst_addr;
    int          beats_seen;     // beats accepted in the current burst
    integer      seed;
    logic [31:0] rand_addr;

    axi_ar_t     exp_ar;
    cache_line_t exp_line;
    logic [1:0]  exp_ret;        // {icache, dcache}
    logic        check_reset;
    logic [5:0]  idle_status;
    logic        any_ret;

    string       test_name;
    int          test_errs;
    int          total_errs;
    int          tests_ok;
    int          tests_bad;
    int          cycles;

    tb_clock #(.period_ns(4.0)) clk0 (.aclk(aclk));

    refill_bridge dut0 (.*);

    // expected AR payload for a refill of the line holding addr
    function automatic axi_ar_t expected_ar(input logic dcache, input logic [31:0] addr);
        axi_ar_t a;
        a       = '0;
        a.id    = dcache ? 4'd1 : 4'd0;   // arid 1 for dcache, 0 for icache
        a.addr  = addr & 32'hFFFF_FFF0;
        a.len   = 4'd3;
        a.size  = 3'd2;
        a.burst = 2'd1;
        return a;
    endfunction

    function automatic cache_line_t expected_line(input logic [31:0] line_addr);
        cache_line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k] = (line_addr + 32'(4 * k)) ^ data_mask;
        end
        return l;
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("FAIL %s: %s expected %h, actual %h", test_name, what, expected, actual);
        test_errs  = test_errs + 1;
        total_errs = total_errs + 1;
    endtask

    task automatic report_problem(input string what);
        $display("error in %s: %s", test_name, what);
        test_errs  = test_errs + 1;
        total_errs = total_errs + 1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        repeat (2) @(posedge aclk);   // let the one-cycle-later checks settle
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
            tests_ok = tests_ok + 1;
        end else begin
            $display("test %s: %0d errors", test_name, test_errs);
            tests_bad = tests_bad + 1;
        end
    endtask

    task automatic expect_refill(input logic dcache, input logic [31:0] addr);
        exp_ar   = expected_ar(dcache, addr);
        exp_line = expected_line(exp_ar.addr);
        exp_ret  = dcache ? 2'b01 : 2'b10;
    endtask

    task automatic raise_req(input logic dcache, input logic [31:0] addr);
        if (dcache) begin
            dcache_rd_req  = 1'b1;
            dcache_rd_addr = addr;
        end else begin
            icache_rd_req  = 1'b1;
            icache_rd_addr = addr;
        end
    endtask

    task automatic wait_accept(input logic dcache);
        @(posedge aclk);
        while (!(dcache ? (dcache_rd_req && dcache_rd_rdy)
                        : (icache_rd_req && icache_rd_rdy))) @(posedge aclk);
    endtask

    task automatic wait_return(input logic dcache);
        @(posedge aclk);
        while (!(dcache ? dcache_ret_valid : icache_ret_valid)) @(posedge aclk);
    endtask

    task automatic refill(input logic dcache, input logic [31:0] addr);
        expect_refill(dcache, addr);
        @(negedge aclk);
        raise_req(dcache, addr);
        wait_accept(dcache);
        @(negedge aclk);
        dcache_rd_req = 1'b0;
        icache_rd_req = 1'b0;
        wait_return(dcache);
    endtask

    // both caches ask in the same cycle and the dcache goes first
    task automatic serve_both(input logic [31:0] d_addr, input logic [31:0] i_addr);
        expect_refill(1'b1, d_addr);
        @(negedge aclk);
        raise_req(1'b1, d_addr);
        raise_req(1'b0, i_addr);
        wait_accept(1'b1);
        @(negedge aclk);
        dcache_rd_req = 1'b0;
        wait_return(1'b1);
        expect_refill(1'b0, i_addr);
        wait_accept(1'b0);
        @(negedge aclk);
        icache_rd_req = 1'b0;
        wait_return(1'b0);
    endtask

    // slave bookkeeping on the rising edge
    always @(posedge aclk) begin
        if (!rst_n) begin
            burst_active <= 1'b0;
            burst_addr   <= '0;
            beats_seen   <= 0;
        end else if (arvalid && arready) begin
            burst_active <= 1'b1;
            burst_addr   <= ar.addr;
            beats_seen   <= 0;
        end else if (rvalid && rready) begin
            beats_seen <= beats_seen + 1;
            if (beats_seen == 3) burst_active <= 1'b0;
        end
    end

    // slave outputs change on the falling edge
    always @(negedge aclk) begin
        arready = rst_n && (stall_mode ? ($random(seed) & 1) != 0 : 1'b1);
        rvalid  = rst_n && burst_active && (stall_mode ? ($random(seed) & 3) != 0 : 1'b1);
        r.id    = '0;
        r.resp  = '0;
        r.data  = (burst_addr + 32'(4 * beats_seen)) ^ data_mask;
        r.last  = (beats_seen == 3);
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    assign idle_status = {arvalid, rready, icache_ret_valid, dcache_ret_valid,
                          icache_rd_rdy, dcache_rd_rdy};
    assign any_ret     = icache_ret_valid || dcache_ret_valid;

    reset_state_check: assert property (@(posedge aclk) disable iff (!rst_n)
        check_reset |-> idle_status == 6'b000011)
        else report_mismatch("idle outputs", 6'b000011, $sampled(idle_status));
    ar_payload_check: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid |-> ar == exp_ar)
        else report_mismatch("ar payload", $sampled(exp_ar), $sampled(ar));
    ar_hold_check: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else report_problem("arvalid dropped or ar changed before the AR handshake");
    priority_check: assert property (@(posedge aclk) disable iff (!rst_n)
        dcache_rd_req |-> !icache_rd_rdy)
        else report_problem("icache_rd_rdy high while the dcache is asking");
    rready_check: assert property (@(posedge aclk) disable iff (!rst_n)
        rready |-> burst_active)
        else report_problem("rready high with no burst in flight");
    owner_check: assert property (@(posedge aclk) disable iff (!rst_n)
        any_ret |-> {icache_ret_valid, dcache_ret_valid} == exp_ret)
        else report_mismatch("ret_valid owner", $sampled(exp_ret),
                             $sampled({icache_ret_valid, dcache_ret_valid}));
    beats_check: assert property (@(posedge aclk) disable iff (!rst_n)
        any_ret |-> beats_seen == 4)
        else report_mismatch("accepted beats", 4, $sampled(beats_seen));
    pulse_check: assert property (@(posedge aclk) disable iff (!rst_n)
        any_ret |=> !any_ret && dcache_rd_rdy)
        else report_problem("ret_valid longer than one cycle or rd_rdy not back");
    icache_line_check: assert property (@(posedge aclk) disable iff (!rst_n)
        icache_ret_valid |-> icache_ret_data == exp_line)
        else report_mismatch("icache line", $sampled(exp_line), $sampled(icache_ret_data));
    dcache_line_check: assert property (@(posedge aclk) disable iff (!rst_n)
        dcache_ret_valid |-> dcache_ret_data == exp_line)
        else report_mismatch("dcache line", $sampled(exp_line), $sampled(dcache_ret_data));

    initial begin
        seed           = 32'h7f534830;
        rst_n          = 1'b0;
        icache_rd_req  = 1'b0;
        icache_rd_addr = '0;
        dcache_rd_req  = 1'b0;
        dcache_rd_addr = '0;
        arready        = 1'b0;
        rvalid         = 1'b0;
        r              = '0;
        stall_mode     = 1'b0;
        check_reset    = 1'b0;
        exp_ar         = '0;
        exp_line       = '0;
        exp_ret        = '0;
        total_errs     = 0;
        tests_ok       = 0;
        tests_bad      = 0;
        cycles         = 0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;

        start_test("reset_state");
        check_reset = 1'b1;
        repeat (3) @(posedge aclk);
        check_reset = 1'b0;
        finish_test();

        start_test("icache_refill");
        refill(1'b0, 32'h0001_2340);
        finish_test();

        start_test("dcache_refill");
        refill(1'b1, 32'h8000_abc0);
        finish_test();

        start_test("address_format");
        refill(1'b1, 32'h0040_567c);   // nonzero offsets
        refill(1'b0, 32'h00ff_ff07);
        finish_test();

        start_test("priority");
        serve_both(32'h0000_3000, 32'h0000_7008);
        finish_test();

        start_test("back_pressure");
        stall_mode = 1'b1;
        for (int i = 0; i < 4; i++) begin
            rand_addr = $random(seed);
            refill(i[0], rand_addr);
        end
        stall_mode = 1'b0;
        finish_test();

        $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && total_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real period_ns = 4.0
) (
    output logic aclk
);

    initial begin
        aclk = 1'b0;
        forever #(period_ns / 2.0) aclk = ~aclk;   // free running
    end

endmodule

`default_nettype wire

// ==== logic/refill_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_bridge (
    input  wire logic                   aclk,
    input  wire logic                   rst_n,
    // icache refill port
    input  wire logic                   icache_rd_req,
    input  wire cache_pkg::line_addr_u  icache_rd_addr,
    output logic                        icache_rd_rdy,
    output logic                        icache_ret_valid,
    output cache_pkg::cache_line_t      icache_ret_data,
    // dcache refill port
    input  wire logic                   dcache_rd_req,
    input  wire cache_pkg::line_addr_u  dcache_rd_addr,
    output logic                        dcache_rd_rdy,
    output logic                        dcache_ret_valid,
    output cache_pkg::cache_line_t      dcache_ret_data,
    // AXI read channels
    output axi_pkg::axi_ar_t            ar,
    output logic                        arvalid,
    input  wire logic                   arready,
    input  wire axi_pkg::axi_r_t        r,
    input  wire logic                   rvalid,
    output logic                        rready
);
    import cache_pkg::*;

    logic        start;
    logic        last_beat;
    cache_line_t line;   // shared by both return ports

    refill_fsm u_fsm (
        .aclk             (aclk),
        .rst_n            (rst_n),
        .icache_rd_req    (icache_rd_req),
        .icache_rd_addr   (icache_rd_addr),
        .dcache_rd_req    (dcache_rd_req),
        .dcache_rd_addr   (dcache_rd_addr),
        .arready          (arready),
        .last_beat        (last_beat),
        .icache_rd_rdy    (icache_rd_rdy),
        .dcache_rd_rdy    (dcache_rd_rdy),
        .icache_ret_valid (icache_ret_valid),
        .dcache_ret_valid (dcache_ret_valid),
        .ar               (ar),
        .arvalid          (arvalid),
        .rready           (rready),
        .start            (start)
    );

    beat_counter u_beat_counter (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .start     (start),
        .rvalid    (rvalid),
        .rready    (rready),
        .last_beat (last_beat)
    );

    line_assembler u_line_assembler (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .rvalid (rvalid),
        .rready (rready),
        .r      (r),
        .line   (line)
    );

    // only the owner's ret_valid marks the data as its own
    assign icache_ret_data = line;
    assign dcache_ret_data = line;

endmodule

`default_nettype wire

// ==== logic/line_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "refill_macros.svh"

module line_assembler (
    input  wire logic               aclk,
    input  wire logic               rst_n,
    input  wire logic               rvalid,
    input  wire logic               rready,
    input  wire axi_pkg::axi_r_t    r,
    output cache_pkg::cache_line_t  line
);

    logic beat;

    assign beat = rvalid && rready;

    // new word enters at the top, older words move down one slot
    // after a full burst the first beat ends up in word 0
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            line <= '0;
        end else if (beat) begin
            line <= {r.data, line[`REFILL_LINE_WORDS-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "refill_macros.svh"

module beat_counter (
    input  wire logic   aclk,
    input  wire logic   rst_n,
    input  wire logic   start,
    input  wire logic   rvalid,
    input  wire logic   rready,
    output logic        last_beat
);

    logic [1:0] count;   // beats taken so far in this line
    logic       beat;

    assign beat = rvalid && rready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (beat) begin
            count <= count + 2'd1;
        end
    end

    // flags the fourth beat while it is being taken
    assign last_beat = beat && (count == 2'(`REFILL_LINE_WORDS - 1));

endmodule

`default_nettype wire

// ==== logic/refill_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "refill_macros.svh"

module refill_fsm (
    input  wire logic               aclk,
    input  wire logic               rst_n,
    input  wire logic               icache_rd_req,
    input  wire cache_pkg::line_addr_u icache_rd_addr,
    input  wire logic               dcache_rd_req,
    input  wire cache_pkg::line_addr_u dcache_rd_addr,
    input  wire logic               arready,
    input  wire logic               last_beat,
    output logic                    icache_rd_rdy,
    output logic                    dcache_rd_rdy,
    output logic                    icache_ret_valid,
    output logic                    dcache_ret_valid,
    output axi_pkg::axi_ar_t        ar,
    output logic                    arvalid,
    output logic                    rready,
    output logic                    start
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        state_idle,
        state_addr,
        state_data,
        state_ret
    } state_t;

    state_t     state;
    logic       owner_dcache;   // owner of the burst in flight
    line_addr_u line_addr;      // line aligned request address
    logic       icache_take;
    logic       dcache_take;

    // dcache wins when both ask in the same cycle
    assign dcache_rd_rdy = (state == state_idle);
    assign icache_rd_rdy = (state == state_idle) && !dcache_rd_req;
    assign dcache_take   = dcache_rd_rdy && dcache_rd_req;
    assign icache_take   = icache_rd_rdy && icache_rd_req;
    assign start         = dcache_take || icache_take;   // also clears the beat count

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state        <= state_idle;
            owner_dcache <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (start) begin
                        state        <= state_addr;
                        owner_dcache <= dcache_take;
                    end
                end
                state_addr: begin
                    if (arready) state <= state_data;   // AR handshake
                end
                state_data: begin
                    if (last_beat) state <= state_ret;
                end
                default: state <= state_idle;   // one cycle return pulse
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            line_addr               <= dcache_take ? dcache_rd_addr : icache_rd_addr;
            line_addr.fields.offset <= '0;
        end
    end

    always_comb begin
        ar       = '0;   // lock, cache, prot left at zero
        ar.id    = owner_dcache ? 4'(`REFILL_ID_DATA) : 4'(`REFILL_ID_INST);
        ar.addr  = line_addr.word;
        ar.len   = 4'(`REFILL_ARLEN);
        ar.size  = 3'(`REFILL_ARSIZE);
        ar.burst = 2'(`REFILL_ARBURST);
    end

    assign arvalid          = (state == state_addr);
    assign rready           = (state == state_data);
    assign icache_ret_valid = (state == state_ret) && !owner_dcache;
    assign dcache_ret_valid = (state == state_ret) && owner_dcache;

endmodule

`default_nettype wire

// ==== logic/cache_pkg.sv ====
`default_nettype none

`include "refill_macros.svh"

package cache_pkg;

    // tag / index / offset view of a cache address
    typedef struct packed {
        logic [`REFILL_TAG_W-1:0]       tag;
        logic [`REFILL_INDEX_W-1:0]     index;
        logic [`REFILL_OFFSET_W-1:0]    offset;   // byte within the line
    } line_fields_t;

    // same 32 bits, seen raw for araddr or split for line alignment
    typedef union packed {
        logic [31:0]    word;
        line_fields_t   fields;
    } line_addr_u;

    // word 0 in the low bits
    typedef logic [`REFILL_LINE_WORDS-1:0][`REFILL_WORD_W-1:0] cache_line_t;

endpackage

`default_nettype wire

// ==== logic/axi_pkg.sv ====
`default_nettype none

`include "refill_macros.svh"

package axi_pkg;

    // read address channel payload, 54 bits
    typedef struct packed {
        logic [3:0]                 id;
        logic [31:0]                addr;
        logic [3:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
        logic [1:0]                 lock;
        logic [3:0]                 cache;
        logic [2:0]                 prot;
    } axi_ar_t;

    // read data channel payload, 39 bits
    typedef struct packed {
        logic [3:0]                 id;
        logic [`REFILL_WORD_W-1:0]  data;
        logic [1:0]                 resp;
        logic                       last;
    } axi_r_t;

endpackage

`default_nettype wire

// ==== logic/refill_macros.svh ====
`ifndef REFILL_MACROS_SVH
`define REFILL_MACROS_SVH

// data path
`define REFILL_WORD_W       32
`define REFILL_LINE_WORDS   4

// AR burst fields for one line refill
`define REFILL_ARLEN        3    // four beats
`define REFILL_ARSIZE       2    // four bytes per beat
`define REFILL_ARBURST      1    // INCR

// arid per requester
`define REFILL_ID_INST      0
`define REFILL_ID_DATA      1

// address split, same as the caches use
`define REFILL_TAG_W        20
`define REFILL_INDEX_W      8
`define REFILL_OFFSET_W     4

`endif
